//--- dmaTop_tests.txt
# Columns, hex: W reg data | R reg expected | S chan expected-addr expected-eop
# M chan = step that must get no addrValid (masked channel)
M 0
W e 00
# channel 2 byte pointer
W 4 34
W 4 12
W 5 02
W 5 00
R 4 34
W c 00
R 4 34
R 4 12
R 5 02
R 5 00
# channel 2 increments to terminal count, then masks itself
S 2 1234 0
S 2 1235 0
S 2 1236 1
M 2
R 8 04
R 8 00
# channel 0 decrement mode
W b 20
W 0 10
W 0 00
W 1 05
W 1 00
S 0 0010 0
S 0 000f 0
S 0 000e 0
R 0 0d
R 0 00
R 1 02
R 1 00
# channel 1 autoinit
W b 11
W 2 00
W 2 02
W 3 01
W 3 00
S 1 0200 0
S 1 0201 1
R 3 01
R 3 00
S 1 0200 0
R 8 02
R 8 00
# mask commands
W a 05
M 1
W a 01
S 1 0201 1
W f 0f
M 0
W f 0e
S 0 000d 0
M 1
# master clear
W d 00
R 4 00
R 4 00
R 3 00
R 3 00
M 0
M 2

//--- dmaTop.f
dmaPkg.sv
dmaBusIf.sv
dmaCommandRegs.sv
dmaChannel.sv
dmaReadPort.sv
dmaTop.sv
dmaTop_checker.sv
dmaTop_tb.sv

//--- run.sh
#!/bin/sh
# Builds the DMA testbench with Verilator, runs it and checks for the pass message
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module dmaTop_tb -f dmaTop.f -o simDma
out=$(./obj_dir/simDma 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

//--- dmaTop_tb.sv
// File-driven testbench for the DMA top level that runs the operations in dmaTop_tests.txt
module dmaTop_tb import dmaPkg::*; ();

  localparam int clkPeriod   = 8;
  localparam int resetCycles = 8;

  logic                    dif;
  logic                    rstN;
  logic                    wrStb;
  logic                    rdStb;
  logic [regAddrWidth-1:0] regAddr;
  logic [dataWidth-1:0]    wrData;
  logic                    step;
  logic [chanIdxWidth-1:0] stepChan;
  logic [dataWidth-1:0]    rdData;
  logic                    rdValid;
  logic [addrWidth-1:0]    addrOut;
  logic                    addrValid;
  logic                    eop;

  byte opQ[$];
  int  argA[$];
  int  argB[$];
  int  argC[$];
  int  numOps;
  bit  loaded;
  int  passCount;
  int  failCount;
  int  seed;
  int  gap;

  dmaTop uut (
    .dif       (dif),
    .rstN      (rstN),
    .wrStb     (wrStb),
    .rdStb     (rdStb),
    .regAddr   (regAddr),
    .wrData    (wrData),
    .step      (step),
    .stepChan  (stepChan),
    .rdData    (rdData),
    .rdValid   (rdValid),
    .addrOut   (addrOut),
    .addrValid (addrValid),
    .eop       (eop)
  );

  initial
  begin
    dif = 1'b0;
  end

  always #(clkPeriod / 2) dif = ~dif;

  // Reads one operation per line and skips lines starting with #
  task automatic loadTests();
    int    fd;
    int    code;
    string line;
    byte   op;
    int    a;
    int    b;
    int    c;
    fd = $fopen("dmaTop_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the test file dmaTop_tests.txt");
      failCount++;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2 || line[0] == "#")
        continue;
      a = 0;
      b = 0;
      c = 0;
      code = $sscanf(line, "%c %h %h %h", op, a, b, c);
      opQ.push_back(op);
      argA.push_back(a);
      argB.push_back(b);
      argC.push_back(c);
    end
    $fclose(fd);
  endtask

  task automatic report(input int idx, input byte op, input bit ok);
    if (ok)
    begin
      passCount++;
      $display("Test %0d (%c) ok", idx, op);
    end
    else
    begin
      failCount++;
      $display("Test %0d (%c) failed", idx, op);
    end
  endtask

  // All operations start and end on a falling edge
  task automatic writeReg(input int idx, input int addr, input int data);
    bit ok;
    ok      = 1'b1;
    wrStb   = 1'b1;
    regAddr = addr[regAddrWidth-1:0];
    wrData  = data[dataWidth-1:0];
    @(posedge dif);
    @(negedge dif);
    wrStb = 1'b0;
    // A write gets neither a read nor a step response
    if (rdValid || addrValid || eop)
    begin
      $display("Test %0d: a write to register %0h got a read or step response", idx, addr);
      ok = 1'b0;
    end
    report(idx, "W", ok);
  endtask

  task automatic readReg(input int idx, input int addr, input int expData);
    bit ok;
    ok      = 1'b1;
    rdStb   = 1'b1;
    regAddr = addr[regAddrWidth-1:0];
    @(posedge dif);
    @(negedge dif);
    rdStb = 1'b0;
    if (!rdValid)
    begin
      $display("Test %0d: no rdValid after a read of register %0h", idx, addr);
      ok = 1'b0;
    end
    else if (rdData !== expData[dataWidth-1:0])
    begin
      $display("** Error test %0d: rdData = %h, expected %h", idx, rdData,
               expData[dataWidth-1:0]);
      ok = 1'b0;
    end
    report(idx, "R", ok);
  endtask

  task automatic stepChannel(input int idx, input int chan, input int expAddr, input int expEop);
    bit ok;
    ok       = 1'b1;
    step     = 1'b1;
    stepChan = chan[chanIdxWidth-1:0];
    @(posedge dif);
    @(negedge dif);
    step = 1'b0;
    if (!addrValid)
    begin
      $display("Test %0d: no addrValid after a step on channel %0d", idx, chan);
      ok = 1'b0;
    end
    else
    begin
      if (addrOut !== expAddr[addrWidth-1:0])
      begin
        $display("** Error test %0d: addrOut = %h, expected %h", idx, addrOut,
                 expAddr[addrWidth-1:0]);
        ok = 1'b0;
      end
      if (eop !== expEop[0])
      begin
        $display("** Error test %0d: eop = %h, expected %h", idx, eop, expEop[0]);
        ok = 1'b0;
      end
    end
    report(idx, "S", ok);
  endtask

  // A masked channel must ignore the step
  task automatic stepMasked(input int idx, input int chan);
    bit ok;
    ok       = 1'b1;
    step     = 1'b1;
    stepChan = chan[chanIdxWidth-1:0];
    @(posedge dif);
    @(negedge dif);
    step = 1'b0;
    if (addrValid || eop)
    begin
      $display("Test %0d: channel %0d should be masked but answered a step", idx, chan);
      ok = 1'b0;
    end
    report(idx, "M", ok);
  endtask

  initial
  begin
    rstN      = 1'b0;
    wrStb     = 1'b0;
    rdStb     = 1'b0;
    regAddr   = '0;
    wrData    = '0;
    step      = 1'b0;
    stepChan  = '0;
    passCount = 0;
    failCount = 0;
    seed      = 60351;
    loadTests();
    numOps = opQ.size();
    loaded = 1'b1;
    repeat (resetCycles) @(negedge dif);
    rstN = 1'b1;
    foreach (opQ[i])
    begin
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) @(negedge dif);
      case (opQ[i])
        "W": writeReg(i, argA[i], argB[i]);
        "R": readReg(i, argA[i], argB[i]);
        "S": stepChannel(i, argA[i], argB[i], argC[i]);
        "M": stepMasked(i, argA[i]);
        default:
        begin
          $display("Test %0d: unknown operation %c in the test file", i, opQ[i]);
          failCount++;
        end
      endcase
    end
    @(negedge dif);
    $display("Tests run %0d, passed %0d, failed %0d", numOps, passCount, failCount);
    if (failCount == 0 && numOps > 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // Up to four cycles per operation plus reset
  initial
  begin
    wait (loaded);
    #((numOps * 4 + 16) * clkPeriod);
    $display("Timeout: the operations did not finish in the expected time");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- dmaTop_checker.sv
// Assertions on the DMA top level's read and step response timing, bound into dmaTop
module dmaTop_checker (
  input logic dif,
  input logic rstN,
  input logic rdStb,
  input logic step,
  input logic rdValid,
  input logic addrValid,
  input logic eop
);

  // Read data one cycle after the strobe, never otherwise
  rdLatency: assert property (@(posedge dif) $past(rstN) |-> (rdValid == $past(rdStb)))
    else $error("rdValid does not follow rdStb by exactly one cycle");

  stepCause: assert property (@(posedge dif) addrValid |-> $past(step))
    else $error("addrValid rose without a step one cycle earlier");

  eopWithAddr: assert property (@(posedge dif) eop |-> addrValid)
    else $error("eop is high without addrValid");

  // Outputs quiet through reset
  resetQuiet: assert property (@(posedge dif) (!rstN && $past(!rstN)) |->
                               (!rdValid && !addrValid && !eop))
    else $error("rdValid, addrValid or eop is high during reset");

endmodule

bind dmaTop dmaTop_checker uChecker (
  .dif       (dif),
  .rstN      (rstN),
  .rdStb     (rdStb),
  .step      (step),
  .rdValid   (rdValid),
  .addrValid (addrValid),
  .eop       (eop)
);

//--- dmaTop.sv
// Four-channel DMA register file top level, instanced by the testbench as the DUT
module dmaTop import dmaPkg::*; (
  input  logic                    dif,
  input  logic                    rstN,
  input  logic                    wrStb,
  input  logic                    rdStb,
  input  logic [regAddrWidth-1:0] regAddr,
  input  logic [dataWidth-1:0]    wrData,
  input  logic                    step,
  input  logic [chanIdxWidth-1:0] stepChan,
  output logic [dataWidth-1:0]    rdData,
  output logic                    rdValid,
  output logic [addrWidth-1:0]    addrOut,
  output logic                    addrValid,
  output logic                    eop
);

  dmaBusIf bus ();

  logic [numChannels-1:0]  autoInit;
  logic [numChannels-1:0]  decrement;
  logic [numChannels-1:0]  masked;
  logic [numChannels-1:0]  stepValid;
  logic [numChannels-1:0]  tcPulse;
  logic [addrWidth-1:0]    currAddr [numChannels];
  logic [addrWidth-1:0]    currCount [numChannels];
  logic [addrWidth-1:0]    stepAddr [numChannels];
  dmaCmd                   rdCmd;
  logic                    rdValidCmd;
  logic [chanIdxWidth-1:0] rdChan;
  logic                    highByte;

  dmaCommandRegs uCmd (
    .dif        (dif),
    .rstN       (rstN),
    .wrStb      (wrStb),
    .rdStb      (rdStb),
    .regAddr    (regAddr),
    .wrData     (wrData),
    .tcPulse    (tcPulse),
    .bus        (bus),
    .autoInit   (autoInit),
    .decrement  (decrement),
    .masked     (masked),
    .rdCmd      (rdCmd),
    .rdValidCmd (rdValidCmd),
    .rdChan     (rdChan),
    .highByte   (highByte)
  );

  for (genvar i = 0; i < numChannels; i++)
  begin : genChan
    dmaChannel #(.chanIndex(i)) uChan (
      .dif       (dif),
      .rstN      (rstN),
      .bus       (bus),
      .autoInit  (autoInit[i]),
      .decrement (decrement[i]),
      .masked    (masked[i]),
      .step      (step),
      .stepChan  (stepChan),
      .currAddr  (currAddr[i]),
      .currCount (currCount[i]),
      .stepAddr  (stepAddr[i]),
      .stepValid (stepValid[i]),
      .tcPulse   (tcPulse[i])
    );
  end

  dmaReadPort uRead (
    .dif        (dif),
    .rstN       (rstN),
    .rdCmd      (rdCmd),
    .rdValidCmd (rdValidCmd),
    .rdChan     (rdChan),
    .highByte   (highByte),
    .currAddr   (currAddr),
    .currCount  (currCount),
    .tcPulse    (tcPulse),
    .rdData     (rdData),
    .rdValid    (rdValid)
  );

  // Only the addressed channel responds, idle ones drive zero
  always_comb
  begin
    addrOut = '0;
    for (int i = 0; i < numChannels; i++)
      addrOut = addrOut | stepAddr[i];
  end

  assign addrValid = |stepValid;
  assign eop       = |tcPulse;

endmodule

//--- dmaReadPort.sv
// Registered CPU read mux with the sticky terminal-count status bits
module dmaReadPort import dmaPkg::*; (
  input  logic                    dif,
  input  logic                    rstN,
  input  dmaCmd                   rdCmd,
  input  logic                    rdValidCmd,
  input  logic [chanIdxWidth-1:0] rdChan,
  input  logic                    highByte,
  input  logic [addrWidth-1:0]    currAddr [numChannels],
  input  logic [addrWidth-1:0]    currCount [numChannels],
  input  logic [numChannels-1:0]  tcPulse,
  output logic [dataWidth-1:0]    rdData,
  output logic                    rdValid
);

  logic [numChannels-1:0] tcBits;
  logic [addrWidth-1:0]   selWord;
  logic [dataWidth-1:0]   selByte;
  logic                   statusRead;

  assign statusRead = rdValidCmd && (rdCmd == cmdStatus);
  assign selWord    = (rdCmd == cmdChanAddr) ? currAddr[rdChan] : currCount[rdChan];
  assign selByte    = highByte ? selWord[addrWidth-1:dataWidth] : selWord[dataWidth-1:0];

  // Status read clears, but a pulse landing on that edge survives
  always_ff @(posedge dif)
  begin
    if (!rstN)
      tcBits <= '0;
    else if (statusRead)
      tcBits <= tcPulse;
    else
      tcBits <= tcBits | tcPulse;
  end

  always_ff @(posedge dif)
  begin
    case (rdCmd)
      cmdChanAddr,
      cmdChanCount: rdData <= selByte;
      cmdStatus:    rdData <= {{(dataWidth-numChannels){1'b0}}, tcBits};
      default:      rdData <= '0;
    endcase
  end

  always_ff @(posedge dif)
  begin
    if (!rstN)
      rdValid <= 1'b0;
    else
      rdValid <= rdValidCmd;
  end

endmodule

//--- dmaChannel.sv
// One DMA channel: base/current address and count registers plus the transfer step
module dmaChannel import dmaPkg::*; #(
  parameter int chanIndex = 0
) (
  input  logic                    dif,
  input  logic                    rstN,
  dmaBusIf.chan                   bus,
  input  logic                    autoInit,
  input  logic                    decrement,
  input  logic                    masked,
  input  logic                    step,
  input  logic [chanIdxWidth-1:0] stepChan,
  output logic [addrWidth-1:0]    currAddr,
  output logic [addrWidth-1:0]    currCount,
  output logic [addrWidth-1:0]    stepAddr,
  output logic                    stepValid,
  output logic                    tcPulse
);

  logic [addrWidth-1:0] baseAddr;
  logic [addrWidth-1:0] baseCount;
  logic                 selected;
  logic                 doStep;
  logic                 atTc;

  // Replace one byte of a 16-bit register
  function automatic logic [addrWidth-1:0] putByte(input logic [addrWidth-1:0] word,
                                                   input logic                  hi,
                                                   input logic [dataWidth-1:0]  data);
    logic [addrWidth-1:0] result;
    result = word;
    if (hi)
      result[addrWidth-1:dataWidth] = data;
    else
      result[dataWidth-1:0] = data;
    return result;
  endfunction

  assign selected = (bus.wrChan == chanIdxWidth'(chanIndex));
  assign doStep   = step && (stepChan == chanIdxWidth'(chanIndex)) && !masked;
  assign atTc     = (currCount == '0);

  always_ff @(posedge dif)
  begin
    if (!rstN || bus.clearAll)
    begin
      baseAddr <= '0;
      currAddr <= '0;
    end
    else if (bus.wrAddr && selected)
    begin
      baseAddr <= putByte(baseAddr, bus.highByte, bus.wrData);
      currAddr <= putByte(currAddr, bus.highByte, bus.wrData);
    end
    else if (doStep)
    begin
      if (atTc && autoInit)
        currAddr <= baseAddr;
      else if (decrement)
        currAddr <= currAddr - 1'b1;
      else
        currAddr <= currAddr + 1'b1;
    end
  end

  // Count wraps to all-ones at terminal count when not reloading
  always_ff @(posedge dif)
  begin
    if (!rstN || bus.clearAll)
    begin
      baseCount <= '0;
      currCount <= '0;
    end
    else if (bus.wrCount && selected)
    begin
      baseCount <= putByte(baseCount, bus.highByte, bus.wrData);
      currCount <= putByte(currCount, bus.highByte, bus.wrData);
    end
    else if (doStep)
    begin
      if (atTc && autoInit)
        currCount <= baseCount;
      else
        currCount <= currCount - 1'b1;
    end
  end

  // Step outputs stay zero when idle so the top can OR them
  always_ff @(posedge dif)
  begin
    if (!rstN)
    begin
      stepAddr  <= '0;
      stepValid <= 1'b0;
      tcPulse   <= 1'b0;
    end
    else
    begin
      stepAddr  <= doStep ? currAddr : '0;
      stepValid <= doStep;
      tcPulse   <= doStep && atTc;
    end
  end

endmodule

//--- dmaCommandRegs.sv
// CPU register-port decoder holding byte pointer, mode bits and channel masks
module dmaCommandRegs import dmaPkg::*; (
  input  logic                    dif,
  input  logic                    rstN,
  input  logic                    wrStb,
  input  logic                    rdStb,
  input  logic [regAddrWidth-1:0] regAddr,
  input  logic [dataWidth-1:0]    wrData,
  input  logic [numChannels-1:0]  tcPulse,
  dmaBusIf.decode                 bus,
  output logic [numChannels-1:0]  autoInit,
  output logic [numChannels-1:0]  decrement,
  output logic [numChannels-1:0]  masked,
  output dmaCmd                   rdCmd,
  output logic                    rdValidCmd,
  output logic [chanIdxWidth-1:0] rdChan,
  output logic                    highByte
);

  dmaCmd                   cmd;
  logic                    bytePtr;
  logic [chanIdxWidth-1:0] wrSelChan;
  logic [numChannels-1:0]  maskBits;
  logic [numChannels-1:0]  maskNext;
  logic [numChannels-1:0]  tcMask;

  assign cmd       = decodeCmd(regAddr);
  assign wrSelChan = wrData[modeChanLsb +: chanIdxWidth];

  // Write strobes go out in the same cycle, channels register them
  assign bus.wrAddr   = wrStb && (cmd == cmdChanAddr);
  assign bus.wrCount  = wrStb && (cmd == cmdChanCount);
  assign bus.wrChan   = regAddr[chanIdxWidth:1];
  assign bus.highByte = bytePtr;
  assign bus.wrData   = wrData;
  assign bus.clearAll = wrStb && (cmd == cmdMasterClear);

  assign rdCmd      = rdStb ? cmd : cmdNone;
  assign rdValidCmd = rdStb;
  assign rdChan     = regAddr[chanIdxWidth:1];
  assign highByte   = bytePtr;

  // Low/high byte flip-flop, toggled by any address or count access
  always_ff @(posedge dif)
  begin
    if (!rstN)
      bytePtr <= 1'b0;
    else if (wrStb && (cmd == cmdClearFf || cmd == cmdMasterClear))
      bytePtr <= 1'b0;
    else if ((wrStb || rdStb) && (cmd == cmdChanAddr || cmd == cmdChanCount))
      bytePtr <= !bytePtr;
  end

  always_ff @(posedge dif)
  begin
    if (!rstN || bus.clearAll)
    begin
      autoInit  <= '0;
      decrement <= '0;
    end
    else if (wrStb && cmd == cmdMode)
    begin
      autoInit[wrSelChan]  <= wrData[modeAutoInitBit];
      decrement[wrSelChan] <= wrData[modeDecrementBit];
    end
  end

  // A channel ending its count without autoinit masks itself at once
  assign tcMask = tcPulse & ~autoInit;
  assign masked = maskBits | tcMask;

  always_comb
  begin
    maskNext = masked;
    if (wrStb)
    begin
      case (cmd)
        cmdMasterClear: maskNext = '1;
        cmdAllMask:     maskNext = wrData[numChannels-1:0];
        cmdClearMask:   maskNext = '0;
        cmdSingleMask:  maskNext[wrSelChan] = wrData[maskSetBit];
        default:        maskNext = masked;
      endcase
    end
  end

  always_ff @(posedge dif)
  begin
    if (!rstN)
      maskBits <= '1;
    else
      maskBits <= maskNext;
  end

endmodule

//--- dmaBusIf.sv
// Decoded register-write bus from the command decoder to every DMA channel
interface dmaBusIf import dmaPkg::*; ();

  logic                    wrAddr;
  logic                    wrCount;
  logic [chanIdxWidth-1:0] wrChan;
  logic                    highByte;
  logic [dataWidth-1:0]    wrData;
  logic                    clearAll;

  modport decode (
    output wrAddr,
    output wrCount,
    output wrChan,
    output highByte,
    output wrData,
    output clearAll
  );

  modport chan (
    input wrAddr,
    input wrCount,
    input wrChan,
    input highByte,
    input wrData,
    input clearAll
  );

endinterface

//--- dmaPkg.sv
// Shared widths, register-port codes, command enum and mode bits; imported by all DMA RTL
package dmaPkg;

  localparam int numChannels  = 4;
  localparam int addrWidth    = 16;
  localparam int dataWidth    = 8;
  localparam int chanIdxWidth = 2;
  localparam int regAddrWidth = 4;

  // 8237 port addresses above the per-channel registers
  localparam logic [regAddrWidth-1:0] regStatus      = 4'd8;
  localparam logic [regAddrWidth-1:0] regSingleMask  = 4'd10;
  localparam logic [regAddrWidth-1:0] regMode        = 4'd11;
  localparam logic [regAddrWidth-1:0] regClearFf     = 4'd12;
  localparam logic [regAddrWidth-1:0] regMasterClear = 4'd13;
  localparam logic [regAddrWidth-1:0] regClearMask   = 4'd14;
  localparam logic [regAddrWidth-1:0] regAllMask     = 4'd15;

  // Bit positions in the mode and single-mask bytes
  localparam int modeChanLsb      = 0;
  localparam int maskSetBit       = 2;
  localparam int modeAutoInitBit  = 4;
  localparam int modeDecrementBit = 5;

  typedef enum logic [3:0] {
    cmdNone,
    cmdChanAddr,
    cmdChanCount,
    cmdStatus,
    cmdSingleMask,
    cmdMode,
    cmdClearFf,
    cmdMasterClear,
    cmdClearMask,
    cmdAllMask
  } dmaCmd;

  // Addresses 0..7 alternate address/count per channel
  function automatic dmaCmd decodeCmd(input logic [regAddrWidth-1:0] regAddr);
    if (!regAddr[regAddrWidth-1])
    begin
      return regAddr[0] ? cmdChanCount : cmdChanAddr;
    end
    case (regAddr)
      regStatus:      return cmdStatus;
      regSingleMask:  return cmdSingleMask;
      regMode:        return cmdMode;
      regClearFf:     return cmdClearFf;
      regMasterClear: return cmdMasterClear;
      regClearMask:   return cmdClearMask;
      regAllMask:     return cmdAllMask;
      default:        return cmdNone;
    endcase
  endfunction

endpackage
